// File: flist.f
+incdir+testbench
source/pipe_pkg.sv
source/instr_decoder.sv
source/stage_reg.sv
source/mdu_occupancy.sv
source/stall_unit.sv
source/hazard_pipe_top.sv
testbench/tb_hazard_pipe.sv

// File: testbench/tb_hazard_tasks.svh
`ifndef TB_HAZARD_TASKS_SVH
`define TB_HAZARD_TASKS_SVH

localparam int C_NONE = 0;
localparam int C_RCALC = 1;
localparam int C_ICALC = 2;
localparam int C_LOAD = 3;
localparam int C_STORE = 4;
localparam int C_BRANCH = 5;
localparam int C_JR = 6;
localparam int C_MD = 7;
localparam int C_MF = 8;
localparam int C_MT = 9;

function automatic logic [31:0] r_word(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                       logic [4:0] rd);
    return {6'h00, rs, rt, rd, 5'd0, fn};
endfunction

function automatic logic [31:0] i_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                       logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] branch_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt);
    return i_word(op, rs, rt, 16'd4);
endfunction

function automatic int word_class(logic [31:0] w);
    if (w[31:26] == OP_SPECIAL) begin
        case (w[5:0])
            FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT: return C_RCALC;
            FN_JR: return C_JR;
            FN_MULT, FN_DIV: return C_MD;
            FN_MFHI, FN_MFLO: return C_MF;
            FN_MTHI, FN_MTLO: return C_MT;
            default: return C_NONE;
        endcase
    end
    case (w[31:26])
        OP_ADDI, OP_ORI, OP_LUI: return C_ICALC;
        OP_LW: return C_LOAD;
        OP_SW: return C_STORE;
        OP_BEQ, OP_BNE: return C_BRANCH;
        default: return C_NONE;
    endcase
endfunction

function automatic logic [4:0] dest_of(logic [31:0] w);
    int c;
    c = word_class(w);
    if (c == C_RCALC || c == C_MF) return w[15:11];
    if (c == C_ICALC || c == C_LOAD) return w[20:16];
    return 5'd0;
endfunction

function automatic logic too_late(logic [4:0] dest, logic [4:0] src, int tnew, int tuse);
    return (dest == src) && (src != 5'd0) && (tnew > tuse);
endfunction

// Stall predicted from the Tuse / Tnew rules
function automatic logic ref_stall_fn(logic [31:0] d, logic [31:0] e, logic [31:0] m, int cnt);
    int dc;
    int ec;
    int tuse_rs;
    int tuse_rt;
    int tnew_e;
    int tnew_m;
    dc = word_class(d);
    ec = word_class(e);
    tuse_rs = 3;
    tuse_rt = 3;
    if (dc == C_BRANCH || dc == C_JR) tuse_rs = 0;
    else if (dc inside {C_RCALC, C_ICALC, C_LOAD, C_STORE, C_MT, C_MD}) tuse_rs = 1;
    if (dc == C_BRANCH) tuse_rt = 0;
    else if (dc == C_RCALC || dc == C_MD) tuse_rt = 1;
    else if (dc == C_STORE) tuse_rt = 2;
    tnew_e = (ec inside {C_RCALC, C_ICALC, C_MF}) ? 1 : (ec == C_LOAD) ? 2 : 0;
    tnew_m = (word_class(m) == C_LOAD) ? 1 : 0;
    return too_late(dest_of(e), d[25:21], tnew_e, tuse_rs) ||
           too_late(dest_of(e), d[20:16], tnew_e, tuse_rt) ||
           too_late(dest_of(m), d[25:21], tnew_m, tuse_rs) ||
           too_late(dest_of(m), d[20:16], tnew_m, tuse_rt) ||
           ((dc inside {C_MD, C_MF, C_MT}) && (ec == C_MD || cnt != 0));
endfunction

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'd0, lcg_state[30:16]};
endfunction

////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////

task automatic drain();
    repeat (14) issue(NOP_WORD);
endtask

task automatic check_count(string name, int exp, int act);
    if (exp != act) begin
        errors++;
        $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

// Two-word sequence with the stall and busy cycles it should cost
task automatic run_pair(logic [31:0] w0, logic [31:0] w1, int exp_stall, int exp_busy);
    drain();
    stall_cycles = 0;
    busy_cycles = 0;
    issue(w0);
    issue(w1);
    drain();
    check_count("stall cycles", exp_stall, stall_cycles);
    check_count("mdu_busy cycles", exp_busy, busy_cycles);
endtask

task automatic test_reset();
    compare_outputs();
    check_val("stall after reset", 32'd0, 32'(stall));
    check_val("mdu_busy after reset", 32'd0, 32'(mdu_busy));
endtask

task automatic test_load_use();
    run_pair(i_word(OP_LW, 29, 8, 0), r_word(FN_ADDU, 8, 9, 10), 1, 0);
    run_pair(i_word(OP_LW, 29, 8, 0), branch_word(OP_BEQ, 8, 0), 2, 0);
    run_pair(i_word(OP_LW, 29, 8, 0), i_word(OP_SW, 29, 8, 4), 0, 0);
endtask

// Branch on r0 after a write to r0 never waits
task automatic test_calc_branch();
    run_pair(r_word(FN_ADDU, 1, 2, 9), branch_word(OP_BEQ, 9, 0), 1, 0);
    run_pair(r_word(FN_ADDU, 1, 2, 0), branch_word(OP_BEQ, 0, 0), 0, 0);
endtask

task automatic test_mdu();
    run_pair(r_word(FN_MULT, 1, 2, 0), r_word(FN_MFHI, 0, 0, 3), MULT_CYC, MULT_CYC - 1);
    run_pair(r_word(FN_DIV, 1, 2, 0), r_word(FN_MFLO, 0, 0, 3), DIV_CYC, DIV_CYC - 1);
    run_pair(r_word(FN_MULT, 1, 2, 0), r_word(FN_ADDU, 4, 5, 6), 0, MULT_CYC - 1);
endtask

task automatic test_pass_through();
    logic [31:0] w [4];
    w[0] = i_word(OP_ORI, 1, 11, 16'h00aa);
    w[1] = i_word(OP_ADDI, 2, 12, 16'h0003);
    w[2] = r_word(FN_SUBU, 3, 4, 13);
    w[3] = i_word(OP_LUI, 0, 14, 16'h1234);
    drain();
    stall_cycles = 0;
    foreach (w[i]) issue(w[i]);
    check_val("d_instr", w[3], d_instr);
    check_val("e_instr", w[2], e_instr);
    check_val("m_instr", w[1], m_instr);
    check_count("stall cycles", 0, stall_cycles);
endtask

// Small register range keeps hazards frequent
task automatic test_mixed();
    logic [31:0] w;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    repeat (200) begin
        rs = 5'(lcg_next() % 8);
        rt = 5'(lcg_next() % 8);
        rd = 5'(lcg_next() % 8);
        case (lcg_next() % 8)
            0: w = r_word(FN_ADDU, rs, rt, rd);
            1: w = i_word(OP_LW, rs, rt, 16'd8);
            2: w = i_word(OP_SW, rs, rt, 16'd4);
            3: w = branch_word(OP_BNE, rs, rt);
            4: w = i_word(OP_ADDI, rs, rt, 16'd1);
            5: w = r_word((rd[0]) ? FN_DIV : FN_MULT, rs, rt, 0);
            6: w = r_word(FN_MFLO, 0, 0, rd);
            default: w = r_word(FN_JR, rs, 0, 0);
        endcase
        issue(w);
    end
    drain();
endtask

`endif

// File: testbench/tb_hazard_pipe.sv
module tb_hazard_pipe;
    timeunit 1ns;
    timeprecision 1ps;
    import pipe_pkg::*;

    localparam int MULT_CYC = 5;
    localparam int DIV_CYC  = 10;

    logic        clk;
    logic        rst_n;
    logic [31:0] fetch_instr;
    logic        stall;
    logic [31:0] d_instr;
    logic [31:0] e_instr;
    logic [31:0] m_instr;
    logic        mdu_busy;

    // Reference copies of the stage contents
    logic [31:0] ref_d;
    logic [31:0] ref_e;
    logic [31:0] ref_m;
    int          ref_cnt;
    logic        ref_stall;

    int          errors;
    int          stall_cycles;
    int          busy_cycles;
    logic [31:0] lcg_state;

    hazard_pipe_top #(
        .MULT_CYCLES (MULT_CYC),
        .DIV_CYCLES  (DIV_CYC)
    ) dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_instr (fetch_instr),
        .stall       (stall),
        .d_instr     (d_instr),
        .e_instr     (e_instr),
        .m_instr     (m_instr),
        .mdu_busy    (mdu_busy)
    );

    always #20 clk = ~clk;

    `include "tb_hazard_tasks.svh"

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // Sampled 2 ns after the edge, outputs settled
    task automatic compare_outputs();
        ref_stall = ref_stall_fn(ref_d, ref_e, ref_m, ref_cnt);
        check_val("stall", 32'(ref_stall), 32'(stall));
        check_val("mdu_busy", 32'(ref_cnt != 0), 32'(mdu_busy));
        check_val("d_instr", ref_d, d_instr);
        check_val("e_instr", ref_e, e_instr);
        check_val("m_instr", ref_m, m_instr);
        if (stall === 1'b1) begin
            stall_cycles++;
        end
        if (mdu_busy === 1'b1) begin
            busy_cycles++;
        end
    endtask

    task automatic advance_model(input logic [31:0] word);
        if (word_class(ref_e) == C_MD) begin
            ref_cnt = (ref_e[5:0] == FN_DIV) ? DIV_CYC - 1 : MULT_CYC - 1;
        end else if (ref_cnt > 0) begin
            ref_cnt--;
        end
        ref_m = ref_e;
        if (ref_stall) begin
            ref_e = NOP_WORD;
        end else begin
            ref_e = ref_d;
            ref_d = word;
        end
    endtask

    // Present a word and hold it until decode takes it
    task automatic issue(input logic [31:0] word);
        int   waited;
        logic accepted;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < 30) begin
            compare_outputs();
            fetch_instr = word;
            accepted    = !ref_stall;
            advance_model(word);
            @(posedge clk);
            #2;
            waited++;
        end
        if (!accepted) begin
            errors++;
            $display("Timeout: word %h was never taken into decode", word);
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch_instr = NOP_WORD;
        errors      = 0;
        lcg_state   = 32'd7;
        ref_d       = NOP_WORD;
        ref_e       = NOP_WORD;
        ref_m       = NOP_WORD;
        ref_cnt     = 0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_reset();
        test_load_use();
        test_calc_branch();
        test_mdu();
        test_pass_through();
        test_mixed();

        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: source/hazard_pipe_top.sv
module hazard_pipe_top #(
    parameter int MULT_CYCLES = pipe_pkg::MULT_CYCLES_DEFAULT,
    parameter int DIV_CYCLES  = pipe_pkg::DIV_CYCLES_DEFAULT
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] fetch_instr,
    output logic        stall,
    output logic [31:0] d_instr,
    output logic [31:0] e_instr,
    output logic [31:0] m_instr,
    output logic        mdu_busy
);
    import pipe_pkg::*;

    stage_t   f_stage;
    stage_t   d_stage;
    stage_t   e_stage;
    stage_t   m_stage;

    decoded_t d_dec;
    decoded_t e_dec;
    decoded_t m_dec;

    logic     mdu_start;

    assign f_stage = '{instr: fetch_instr};
    assign d_instr = d_stage.instr;
    assign e_instr = e_stage.instr;
    assign m_instr = m_stage.instr;

    ///////////////////////////////////////////////////////////////////////
    // Stage registers
    ///////////////////////////////////////////////////////////////////////

    // Decode holds its word during a stall
    stage_reg #(.payload_t(stage_t)) fd_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (stall),
        .bubble (1'b0),
        .d      (f_stage),
        .q      (d_stage)
    );

    // Execute takes a bubble during a stall
    stage_reg #(.payload_t(stage_t)) de_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (1'b0),
        .bubble (stall),
        .d      (d_stage),
        .q      (e_stage)
    );

    stage_reg #(.payload_t(stage_t)) em_reg (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (1'b0),
        .bubble (1'b0),
        .d      (e_stage),
        .q      (m_stage)
    );

    ///////////////////////////////////////////////////////////////////////
    // Per-stage decode and hazard logic
    ///////////////////////////////////////////////////////////////////////

    instr_decoder d_decoder (.instr(d_stage.instr), .dec(d_dec));
    instr_decoder e_decoder (.instr(e_stage.instr), .dec(e_dec));
    instr_decoder m_decoder (.instr(m_stage.instr), .dec(m_dec));

    mdu_occupancy #(
        .MULT_CYCLES (MULT_CYCLES),
        .DIV_CYCLES  (DIV_CYCLES)
    ) mdu_track (
        .clk   (clk),
        .rst_n (rst_n),
        .e_dec (e_dec),
        .start (mdu_start),
        .busy  (mdu_busy)
    );

    stall_unit hazard_ctrl (
        .d_dec     (d_dec),
        .e_dec     (e_dec),
        .m_dec     (m_dec),
        .mdu_start (mdu_start),
        .mdu_busy  (mdu_busy),
        .stall     (stall)
    );

endmodule

// File: source/stall_unit.sv
module stall_unit (
    input  pipe_pkg::decoded_t d_dec,
    input  pipe_pkg::decoded_t e_dec,
    input  pipe_pkg::decoded_t m_dec,
    input  logic               mdu_start,
    input  logic               mdu_busy,
    output logic               stall
);
    import pipe_pkg::*;

    tcode_t tuse_rs;
    tcode_t tuse_rt;
    tcode_t e_tnew;
    tcode_t m_tnew;

    logic e_stall_rs;
    logic e_stall_rt;
    logic m_stall_rs;
    logic m_stall_rt;
    logic mdu_stall;

    // True when a result from an older stage arrives too late
    function automatic logic conflict(
        input reg_addr_t dest,
        input reg_addr_t src,
        input tcode_t    tnew,
        input tcode_t    tuse
    );
        logic same_reg;
        same_reg = (dest == src) && (src != '0);
        return same_reg && (tnew > tuse);
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Tuse in decode
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        if (d_dec.branch || d_dec.jump_reg) begin
            tuse_rs = 3'd0;
        end else if (d_dec.r_calc || d_dec.i_calc || d_dec.load || d_dec.store ||
                     d_dec.mt || d_dec.md) begin
            tuse_rs = 3'd1;
        end else begin
            tuse_rs = TCODE_NONE;
        end
    end

    always_comb begin
        if (d_dec.branch) begin
            tuse_rt = 3'd0;
        end else if (d_dec.r_calc || d_dec.md) begin
            tuse_rt = 3'd1;
        end else if (d_dec.store) begin
            // Store data is needed only in memory
            tuse_rt = 3'd2;
        end else begin
            tuse_rt = TCODE_NONE;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Tnew in execute and memory
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        if (e_dec.r_calc || e_dec.i_calc || e_dec.mf) begin
            e_tnew = 3'd1;
        end else if (e_dec.load) begin
            e_tnew = 3'd2;
        end else begin
            e_tnew = 3'd0;
        end
    end

    assign m_tnew = m_dec.load ? 3'd1 : 3'd0;

    // Register conflicts
    assign e_stall_rs = conflict(e_dec.dest, d_dec.rs, e_tnew, tuse_rs);
    assign e_stall_rt = conflict(e_dec.dest, d_dec.rt, e_tnew, tuse_rt);
    assign m_stall_rs = conflict(m_dec.dest, d_dec.rs, m_tnew, tuse_rs);
    assign m_stall_rt = conflict(m_dec.dest, d_dec.rt, m_tnew, tuse_rt);

    // Any HI/LO access waits for the unit to drain
    assign mdu_stall = (d_dec.md || d_dec.mf || d_dec.mt) && (mdu_start || mdu_busy);

    assign stall = e_stall_rs | e_stall_rt | m_stall_rs | m_stall_rt | mdu_stall;

endmodule

// File: source/mdu_occupancy.sv
module mdu_occupancy #(
    parameter int MULT_CYCLES = pipe_pkg::MULT_CYCLES_DEFAULT,
    parameter int DIV_CYCLES  = pipe_pkg::DIV_CYCLES_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n,
    input  pipe_pkg::decoded_t e_dec,
    output logic               start,
    output logic               busy
);
    import pipe_pkg::*;

    localparam int MAX_CYCLES = (DIV_CYCLES > MULT_CYCLES) ? DIV_CYCLES : MULT_CYCLES;
    localparam int CNT_W      = $clog2(MAX_CYCLES + 1);

    // Cycles left after the start cycle
    localparam logic [CNT_W-1:0] MULT_LOAD = CNT_W'(MULT_CYCLES - 1);
    localparam logic [CNT_W-1:0] DIV_LOAD  = CNT_W'(DIV_CYCLES - 1);

    decoded_t         op_dec;
    logic [CNT_W-1:0] count;

    assign op_dec = e_dec;

    // mult or div sitting in execute
    assign start = op_dec.md;

    ///////////////////////////////////////////////////////////////////////
    // Busy down-counter
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= op_dec.is_div ? DIV_LOAD : MULT_LOAD;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign busy = (count != '0);

endmodule

// File: source/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    ///////////////////////////////////////////////////////////////////////
    // Stage register
    ///////////////////////////////////////////////////////////////////////

    // All-zero payload is the bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (hold) begin
            q <= q;
        end else if (bubble) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

// File: source/instr_decoder.sv
module instr_decoder (
    input  logic [31:0]        instr,
    output pipe_pkg::decoded_t dec
);
    import pipe_pkg::*;

    op_t       op;
    funct_t    fn;
    reg_addr_t rd;

    // Field slices
    assign op = op_t'(instr[31:26]);
    assign fn = funct_t'(instr[5:0]);
    assign rd = instr[15:11];

    ///////////////////////////////////////////////////////////////////////
    // Class flags
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        dec      = '0;
        dec.rs   = instr[25:21];
        dec.rt   = instr[20:16];

        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT: begin
                        dec.r_calc = 1'b1;
                    end
                    FN_JR: begin
                        dec.jump_reg = 1'b1;
                    end
                    FN_MULT: begin
                        dec.md = 1'b1;
                    end
                    FN_DIV: begin
                        dec.md     = 1'b1;
                        dec.is_div = 1'b1;
                    end
                    FN_MFHI, FN_MFLO: begin
                        dec.mf = 1'b1;
                    end
                    FN_MTHI, FN_MTLO: begin
                        dec.mt = 1'b1;
                    end
                    // sll and anything else behaves as a bubble
                    default: ;
                endcase
            end
            OP_ADDI, OP_ORI, OP_LUI: begin
                dec.i_calc = 1'b1;
            end
            OP_LW: begin
                dec.load = 1'b1;
            end
            OP_SW: begin
                dec.store = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                dec.branch = 1'b1;
            end
            default: ;
        endcase

        // Destination register by class
        if (dec.r_calc || dec.mf) begin
            dec.dest = rd;
        end else if (dec.i_calc || dec.load) begin
            dec.dest = dec.rt;
        end else begin
            dec.dest = '0;
        end
    end

endmodule

// File: source/pipe_pkg.sv
package pipe_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ///////////////////////////////////////////////////////////////////////

    // Primary opcodes, bits [31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } op_t;

    // SPECIAL funct field, bits [5:0]
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_MFHI = 6'h10,
        FN_MTHI = 6'h11,
        FN_MFLO = 6'h12,
        FN_MTLO = 6'h13,
        FN_MULT = 6'h18,
        FN_DIV  = 6'h1a,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_t;

    typedef logic [4:0] reg_addr_t;

    // Tuse / Tnew in cycles, 3 means the operand is never read
    typedef logic [2:0] tcode_t;

    localparam tcode_t TCODE_NONE = 3'd3;

    ///////////////////////////////////////////////////////////////////////
    // Decoded instruction and stage payload
    ///////////////////////////////////////////////////////////////////////

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        logic      r_calc;
        logic      i_calc;
        logic      load;
        logic      store;
        logic      branch;
        logic      jump_reg;
        logic      md;
        logic      mf;
        logic      mt;
        logic      is_div;
    } decoded_t;

    typedef struct packed {
        logic [31:0] instr;
    } stage_t;

    // sll r0, r0, 0 encodes as all zeros
    localparam logic [31:0] NOP_WORD = 32'h0000_0000;

    localparam int MULT_CYCLES_DEFAULT = 5;
    localparam int DIV_CYCLES_DEFAULT  = 10;

endpackage
